/* Makefile */
VERILATOR ?= verilator
TOP       ?= ooo_core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT := Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* hdl/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter type payload_t = logic
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic [1:0]           request,
    input  payload_t [1:0]       payload,
    output logic [1:0]           grant,
    output logic                 bus_valid,
    output payload_t             bus_payload
);

    // Index of the requester served most recently
    logic last_grant;

    // On a tie the requester not served last time wins
    always_comb begin
        grant[0] = request[0] && (!request[1] || last_grant);
        grant[1] = request[1] && (!request[0] || !last_grant);
    end

    assign bus_valid = |request;

    always_comb begin
        if (grant[1]) begin
            bus_payload = payload[1];
        end else begin
            bus_payload = payload[0]; // Also the idle value
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            last_grant <= 1'b1; // Requester 0 goes first
        end else if (bus_valid) begin
            last_grant <= grant[1];
        end
    end

endmodule

/* hdl/exec_pkg.sv */
package exec_pkg;

    // One execution unit per dispatch lane
    localparam int num_units = 2;

    localparam int word_bits = 16; // Operand and result width
    localparam int id_bits   = 4;  // Reorder-buffer tag width

    typedef enum logic {
        op_add = 1'b0,
        op_mul = 1'b1
    } op_t;

    // Work sent from dispatch to an execution unit
    typedef struct packed {
        logic [word_bits-1:0] src_a;
        logic [word_bits-1:0] src_b;
        op_t                  op;
        logic [id_bits-1:0]   tag;
    } issue_t;

    // Result broadcast on the completion bus
    typedef struct packed {
        logic [id_bits-1:0]   tag;
        logic [word_bits-1:0] result;
    } completion_t;

endpackage

/* hdl/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit #(
    parameter int latency = 1
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  exec_pkg::issue_t      issue,
    output logic                  ready,
    output logic                  request,
    input  logic                  grant,
    output exec_pkg::completion_t result
);

    import exec_pkg::*;

    logic [latency-1:0] stage_valid;
    completion_t        stage_data [latency];
    logic               res_valid;
    completion_t        res_data;
    logic               advance;
    logic [2*word_bits-1:0] product;
    completion_t        computed;

    // Whole pipeline moves together when the result register can take a value
    assign advance = !res_valid || grant;
    assign ready   = advance;

    assign product = issue.src_a * issue.src_b;

    always_comb begin
        computed.tag = issue.tag;
        if (issue.op == op_mul) begin
            computed.result = product[word_bits-1:0]; // Low half only
        end else begin
            computed.result = issue.src_a + issue.src_b;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
            res_valid   <= 1'b0;
        end else if (advance) begin
            stage_valid[0] <= issue_valid;
            for (int i = 1; i < latency; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
            res_valid <= stage_valid[latency-1];
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            stage_data[0] <= computed;
            for (int i = 1; i < latency; i++) begin
                stage_data[i] <= stage_data[i-1];
            end
            res_data <= stage_data[latency-1];
        end
    end

    assign request = res_valid; // Held until granted
    assign result  = res_data;

endmodule

/* hdl/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core #(
    parameter int rob_depth   = 8,
    parameter int mul_latency = 3
) (
    input  logic                                             clock,
    input  logic                                             reset,
    input  rob_pkg::rob_entry_t [rob_pkg::dispatch_width-1:0] dispatch_group,
    input  logic [rob_pkg::count_bits-1:0]                   dispatch_count,
    output logic [rob_pkg::count_bits-1:0]                   spots,
    output logic [1:0]                                       unit_ready,
    output rob_pkg::retire_t [rob_pkg::dispatch_width-1:0]   retire_group,
    output logic [rob_pkg::count_bits-1:0]                   retire_count
);

    import rob_pkg::*;
    import exec_pkg::*;

    logic [dispatch_width-1:0][tag_bits-1:0] alloc_tags;
    issue_t                       add_issue;
    issue_t                       mul_issue;
    logic [1:0]                   request;
    logic [1:0]                   grant;
    completion_t [1:0]            unit_result;
    logic                         bus_valid;
    completion_t                  bus_payload;
    rob_exit_t [dispatch_width-1:0] exit_window;
    logic [count_bits-1:0]        exit_count;
    logic [count_bits-1:0]        num_retiring;

    // Lane fixes the operation: lane 0 adds, lane 1 multiplies
    assign add_issue = '{src_a: dispatch_group[0].src_a, src_b: dispatch_group[0].src_b,
                         op: op_add, tag: alloc_tags[0]};
    assign mul_issue = '{src_a: dispatch_group[1].src_a, src_b: dispatch_group[1].src_b,
                         op: op_mul, tag: alloc_tags[1]};

    rob #(.rob_depth(rob_depth)) rob_inst (
        .clock        (clock),
        .reset        (reset),
        .alloc_entries(dispatch_group),
        .alloc_count  (dispatch_count),
        .alloc_tags   (alloc_tags),
        .bus_valid    (bus_valid),
        .bus_payload  (bus_payload),
        .num_retiring (num_retiring),
        .exit_window  (exit_window),
        .exit_count   (exit_count),
        .spots        (spots)
    );

    exec_unit #(.latency(1)) add_unit (
        .clock      (clock),
        .reset      (reset),
        .issue_valid(dispatch_count > 2'd0),
        .issue      (add_issue),
        .ready      (unit_ready[0]),
        .request    (request[0]),
        .grant      (grant[0]),
        .result     (unit_result[0])
    );

    exec_unit #(.latency(mul_latency)) mul_unit (
        .clock      (clock),
        .reset      (reset),
        .issue_valid(dispatch_count > 2'd1),
        .issue      (mul_issue),
        .ready      (unit_ready[1]),
        .request    (request[1]),
        .grant      (grant[1]),
        .result     (unit_result[1])
    );

    cdb_arbiter #(.payload_t(completion_t)) arbiter (
        .clock      (clock),
        .reset      (reset),
        .request    (request),
        .payload    (unit_result),
        .grant      (grant),
        .bus_valid  (bus_valid),
        .bus_payload(bus_payload)
    );

    retire_stage #(.rob_depth(rob_depth)) retire (
        .exit_window (exit_window),
        .exit_count  (exit_count),
        .num_retiring(num_retiring),
        .retire_group(retire_group),
        .retire_count(retire_count)
    );

endmodule

/* hdl/retire_stage.sv */
`timescale 1ns/1ps

module retire_stage #(
    parameter int rob_depth = 8
) (
    input  rob_pkg::rob_exit_t [rob_pkg::dispatch_width-1:0] exit_window,
    input  logic [rob_pkg::count_bits-1:0]                   exit_count,
    output logic [rob_pkg::count_bits-1:0]                   num_retiring,
    output rob_pkg::retire_t [rob_pkg::dispatch_width-1:0]   retire_group,
    output logic [rob_pkg::count_bits-1:0]                   retire_count
);

    import rob_pkg::*;

    // A tiny buffer cannot show more entries than it holds
    localparam int scan_width = (rob_depth < dispatch_width) ? rob_depth : dispatch_width;

    logic [count_bits-1:0] leading;

    // Count complete entries from the head, stopping at the first gap
    always_comb begin
        logic blocked;
        blocked = 1'b0;
        leading = '0;
        for (int i = 0; i < scan_width; i++) begin
            if (!blocked && (i < int'(exit_count)) && exit_window[i].complete) begin
                leading = leading + 1'b1;
            end else begin
                blocked = 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < dispatch_width; i++) begin
            if (i < int'(leading)) begin
                retire_group[i].dest   = exit_window[i].dest;
                retire_group[i].result = exit_window[i].result;
            end else begin
                retire_group[i] = '0;
            end
        end
    end

    // Same count frees the ROB and reaches the outputs
    assign num_retiring = leading;
    assign retire_count = leading;

endmodule

/* hdl/rob.sv */
`timescale 1ns/1ps

module rob #(
    parameter int rob_depth = 8
) (
    input  logic                                                clock,
    input  logic                                                reset,
    input  rob_pkg::rob_entry_t [rob_pkg::dispatch_width-1:0]   alloc_entries, // Oldest first
    input  logic [rob_pkg::count_bits-1:0]                      alloc_count,
    output logic [rob_pkg::dispatch_width-1:0][rob_pkg::tag_bits-1:0] alloc_tags,
    input  logic                                                bus_valid,
    input  exec_pkg::completion_t                               bus_payload,
    input  logic [rob_pkg::count_bits-1:0]                      num_retiring,
    output rob_pkg::rob_exit_t [rob_pkg::dispatch_width-1:0]    exit_window,
    output logic [rob_pkg::count_bits-1:0]                      exit_count,
    output logic [rob_pkg::count_bits-1:0]                      spots
);

    import rob_pkg::*;

    localparam int idx_bits = (rob_depth > 1) ? $clog2(rob_depth) : 1;
    localparam int occ_bits = $clog2(rob_depth + 1);
    localparam logic [occ_bits-1:0] depth_value = occ_bits'(rob_depth);

    // Per-entry storage
    logic [reg_bits-1:0]  dest_mem     [rob_depth];
    logic [data_bits-1:0] result_mem   [rob_depth];
    logic                 complete_mem [rob_depth];

    logic [idx_bits-1:0] head;
    logic [idx_bits-1:0] tail;
    logic [occ_bits-1:0] occupancy;
    logic [occ_bits-1:0] free_entries;

    logic [idx_bits-1:0] alloc_index [dispatch_width];
    logic [idx_bits-1:0] bus_index;

    // Pointer step that wraps at rob_depth, which need not be a power of two
    function automatic logic [idx_bits-1:0] wrap_index(
        input logic [idx_bits-1:0]   base,
        input logic [count_bits-1:0] offset
    );
        logic [idx_bits:0] sum;
        sum = (idx_bits + 1)'(base) + (idx_bits + 1)'(offset);
        if (sum >= (idx_bits + 1)'(rob_depth)) begin
            sum = sum - (idx_bits + 1)'(rob_depth);
        end
        return sum[idx_bits-1:0];
    endfunction

    assign bus_index    = idx_bits'(bus_payload.tag);
    assign free_entries = depth_value - occupancy;

    always_comb begin
        // Saturate both counts at the group width
        if (free_entries >= occ_bits'(dispatch_width)) begin
            spots = count_bits'(dispatch_width);
        end else begin
            spots = count_bits'(free_entries);
        end
        if (occupancy >= occ_bits'(dispatch_width)) begin
            exit_count = count_bits'(dispatch_width);
        end else begin
            exit_count = count_bits'(occupancy);
        end
    end

    always_comb begin
        for (int i = 0; i < dispatch_width; i++) begin
            alloc_index[i] = wrap_index(tail, count_bits'(i));
            alloc_tags[i]  = tag_bits'(alloc_index[i]);
        end
    end

    // Head window, read oldest first
    always_comb begin
        logic [idx_bits-1:0] slot;
        for (int i = 0; i < dispatch_width; i++) begin
            slot = wrap_index(head, count_bits'(i));
            exit_window[i].dest     = dest_mem[slot];
            exit_window[i].result   = result_mem[slot];
            exit_window[i].complete = complete_mem[slot];
            exit_window[i].tag      = tag_bits'(slot);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= wrap_index(head, num_retiring);
            tail      <= wrap_index(tail, alloc_count);
            occupancy <= occupancy + occ_bits'(alloc_count) - occ_bits'(num_retiring);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < dispatch_width; i++) begin
            if (i < int'(alloc_count)) begin
                dest_mem[alloc_index[i]]     <= alloc_entries[i].dest;
                complete_mem[alloc_index[i]] <= 1'b0; // Fresh entry waits for its result
            end
        end
        // A completing tag is always occupied, so it never collides with a new entry
        if (bus_valid) begin
            result_mem[bus_index]   <= bus_payload.result;
            complete_mem[bus_index] <= 1'b1;
        end
    end

endmodule

/* hdl/rob_pkg.sv */
package rob_pkg;

    // Group width follows the number of execution units
    localparam int dispatch_width = exec_pkg::num_units;
    localparam int count_bits     = 2; // Holds 0 to dispatch_width

    localparam int tag_bits  = exec_pkg::id_bits;   // Depth up to 16
    localparam int data_bits = exec_pkg::word_bits;
    localparam int reg_bits  = 5;

    // One dispatched instruction
    typedef struct packed {
        logic [reg_bits-1:0]  dest;
        exec_pkg::op_t        op;
        logic [data_bits-1:0] src_a;
        logic [data_bits-1:0] src_b;
    } rob_entry_t;

    // Head-window view of an occupied entry
    typedef struct packed {
        logic [reg_bits-1:0]  dest;
        logic [data_bits-1:0] result;
        logic                 complete;
        logic [tag_bits-1:0]  tag;
    } rob_exit_t;

    // Architectural update leaving the core
    typedef struct packed {
        logic [reg_bits-1:0]  dest;
        logic [data_bits-1:0] result;
    } retire_t;

endpackage

/* sources.f */
hdl/exec_pkg.sv
hdl/rob_pkg.sv
hdl/rob.sv
hdl/exec_unit.sv
hdl/cdb_arbiter.sv
hdl/retire_stage.sv
hdl/ooo_core.sv
testbench/ooo_core_checker.sv
testbench/ooo_core_tb.sv

/* testbench/ooo_core_checker.sv */
`timescale 1ns/1ps

module ooo_core_checker #(
    parameter int rob_depth    = 8,
    parameter int payload_bits = 20
) (
    input logic                    clock,
    input logic                    reset,
    input logic [1:0]              grant,
    input logic                    bus_valid,
    input logic [payload_bits-1:0] bus_payload,
    input logic [1:0]              spots,
    input logic [1:0]              exit_count,
    input logic [1:0]              retire_count
);

    import exec_pkg::*;

    int          failure_count = 0;
    completion_t completion;

    assign completion = bus_payload;

    grant_one_hot: assert property (@(posedge clock) disable iff (reset) $onehot0(grant))
        else begin $error("grant has more than one bit set"); failure_count++; end

    // Tag on the bus must point into the ROB
    tag_in_range: assert property (@(posedge clock) disable iff (reset)
        bus_valid |-> (int'(completion.tag) < rob_depth))
        else begin $error("completion tag outside the ROB"); failure_count++; end

    spots_limit: assert property (@(posedge clock) disable iff (reset) spots <= 2'd2)
        else begin $error("spots above the dispatch width"); failure_count++; end

    retire_limit: assert property (@(posedge clock) disable iff (reset)
        retire_count <= exit_count)
        else begin $error("retire_count above exit_count"); failure_count++; end

    reset_quiet: assert property (@(posedge clock)
        reset |=> (!bus_valid && retire_count == 2'd0))
        else begin $error("bus or retire active after reset"); failure_count++; end

endmodule

bind ooo_core ooo_core_checker #(.rob_depth(rob_depth)) checks (
    .clock(clock), .reset(reset), .grant(grant), .bus_valid(bus_valid),
    .bus_payload(bus_payload), .spots(spots), .exit_count(exit_count),
    .retire_count(retire_count)
);

/* testbench/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb;

    import rob_pkg::*;
    import exec_pkg::*;

    localparam int num_rows      = 36;
    localparam int timeout_limit = 40 * num_rows + 100;

    // One dispatch group and the results it should retire
    typedef struct packed {
        logic [count_bits-1:0]           count;
        rob_entry_t [dispatch_width-1:0] entries;
        retire_t [dispatch_width-1:0]    expected;
    } row_t;

    logic                            clock;
    logic                            reset;
    rob_entry_t [dispatch_width-1:0] dispatch_group;
    logic [count_bits-1:0]           dispatch_count;
    logic [count_bits-1:0]           spots;
    logic [1:0]                      unit_ready;
    retire_t [dispatch_width-1:0]    retire_group;
    logic [count_bits-1:0]           retire_count;

    row_t    stimulus [num_rows];
    retire_t expected_q [$];
    retire_t expect_item;
    int      error_count = 0;
    int      cycle_count = 0;
    logic    saw_full = 1'b0; // Set once spots reaches zero

    // Six entries fill under full-rate pairs and wrap off a power of two
    ooo_core #(.rob_depth(6), .mul_latency(3)) uut (
        .clock(clock), .reset(reset), .dispatch_group(dispatch_group),
        .dispatch_count(dispatch_count), .spots(spots), .unit_ready(unit_ready),
        .retire_group(retire_group), .retire_count(retire_count)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
            error_count++;
        end
    endtask

    // Lane 0 adds, lane 1 keeps the low half of the product
    task automatic set_row(input int idx, input int count, input logic [15:0] a0,
                           input logic [15:0] b0, input logic [15:0] a1, input logic [15:0] b1);
        logic [31:0] product;
        product = a1 * b1;
        stimulus[idx].count      = count_bits'(count);
        stimulus[idx].entries[0] = '{dest: reg_bits'(2 * idx + 1), op: op_add,
                                     src_a: a0, src_b: b0};
        stimulus[idx].entries[1] = '{dest: reg_bits'(2 * idx + 2), op: op_mul,
                                     src_a: a1, src_b: b1};
        stimulus[idx].expected[0] = '{dest: reg_bits'(2 * idx + 1), result: a0 + b0};
        stimulus[idx].expected[1] = '{dest: reg_bits'(2 * idx + 2), result: product[15:0]};
    endtask

    task automatic build_table();
        int mix_counts [14] = '{1, 0, 2, 1, 1, 0, 0, 2, 1, 0, 2, 1, 1, 2};
        set_row(0, 2, 16'h0003, 16'h0004, 16'h0005, 16'h0006);
        set_row(1, 2, 16'h00ff, 16'h0001, 16'h0100, 16'h0100);
        set_row(2, 2, 16'hffff, 16'h0002, 16'h1234, 16'h0010);
        set_row(3, 2, 16'h8000, 16'h8000, 16'hffff, 16'hffff);
        set_row(4, 2, 16'h0a0a, 16'h0505, 16'h00c8, 16'h0064);
        set_row(5, 2, 16'h0000, 16'h0000, 16'h7fff, 16'h0003);
        // Back-to-back pairs, long enough to wrap head and tail
        for (int i = 6; i < 22; i++) begin
            set_row(i, 2, 16'($urandom), 16'($urandom), 16'($urandom), 16'($urandom));
        end
        for (int i = 0; i < 14; i++) begin
            set_row(22 + i, mix_counts[i], 16'(i * 257), 16'(i + 3), 16'($urandom),
                    16'(i * 7 + 1));
        end
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_group = '0;
        dispatch_count = '0;
        void'($urandom(32'ha9493c40));
        build_table();
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
        check_value("spots", spots, 2);
        check_value("unit_ready", unit_ready, 2'b11);
        check_value("retire_count", retire_count, 0);
        for (int r = 0; r < num_rows; r++) begin
            dispatch_count = '0;
            // Hold the row until free entries and the needed lanes allow it
            while (!((stimulus[r].count <= spots) &&
                     (stimulus[r].count < 2'd1 || unit_ready[0]) &&
                     (stimulus[r].count < 2'd2 || unit_ready[1]))) begin
                @(posedge clock);
                #1;
            end
            dispatch_group = stimulus[r].entries;
            dispatch_count = stimulus[r].count;
            for (int i = 0; i < int'(stimulus[r].count); i++) begin
                expected_q.push_back(stimulus[r].expected[i]);
            end
            @(posedge clock);
            #1;
        end
        dispatch_count = '0;
        dispatch_group = '0;
        while (expected_q.size() != 0) @(posedge clock);
        repeat (2) @(posedge clock);
        #1;
        check_value("spots", spots, 2); // Drained core is idle again
        check_value("unit_ready", unit_ready, 2'b11);
        check_value("saw_full", saw_full, 1);
        error_count = error_count + uut.checks.failure_count;
        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Retire outputs are settled mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            if (spots == '0) saw_full = 1'b1;
            for (int i = 0; i < int'(retire_count); i++) begin
                if (expected_q.size() == 0) begin
                    $display("An instruction retired with none left outstanding");
                    error_count++;
                end else begin
                    expect_item = expected_q.pop_front();
                    check_value($sformatf("retire_group[%0d].dest", i),
                                retire_group[i].dest, expect_item.dest);
                    check_value($sformatf("retire_group[%0d].result", i),
                                retire_group[i].result, expect_item.result);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles with %0d instructions not retired",
                     cycle_count, expected_q.size());
            $display("Errors: %0d", error_count + 1);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule
